// File: Makefile
# Verilator build and run of the decoder testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
TOP       := cop_bus_tb
FILELIST  := tb.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q '^Simulation PASSED$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/cop_bus_tb.sv
// testbench for the main-CPU decoder that runs bus accesses and checks selects and read-back words
`timescale 1ns/1ps

module cop_bus_tb import cop_bus_pkg::*; ();

    localparam int ROM_BANKS = 6;
    // accesses per group for strobe off, rom, bank steps, decode, read-back, reset and vblank slack
    localparam int N_ACC = 8 + 20 + 71 + 32 + 48 + 12;
    localparam int WATCHDOG_NS = 2 * N_ACC * 4 * 20;  // 4 cycles per access at a 20 ns clock

    // expected outputs of one access
    typedef struct packed {
        chip_sel_t  sel;
        io_word_t   rdata;
        logic [5:0] sec;
    } expect_t;

    // every tilemap window that depends on the bank
    localparam logic [23:0] MAP_ADDR [9] = '{
        24'h118000, 24'h11C000, 24'h24E000, 24'h262000, 24'h26E000,
        24'h270000, 24'h246000, 24'h260000, 24'h278000
    };

    // fixed windows plus a few holes that select nothing
    localparam logic [23:0] DEC_ADDR [16] = '{
        24'h248000, 24'h24C000, 24'h240000, 24'h242000,
        24'h300000, 24'h300800, 24'h301000, 24'h301800,  // chr mode, map, sft, hole
        24'h304000, 24'h31C000, 24'h308000, 24'h310000,
        24'h314000, 24'h314002, 24'h314006, 24'h32C000
    };

    logic       clk = 1'b0;
    logic       rst;
    cpu_bus_t   bus;
    cab_in_t    cab;
    logic       lvbl;
    io_word_t   dip_sw;
    io_word_t   cab_io;
    chip_sel_t  sel;
    io_word_t   rdata;
    logic       obj_copy;
    logic [5:0] sec;

    integer      seed = 32'he2bea164;
    logic [31:0] rnd;
    logic [1:0]  bank_m;      // model of the map bank
    int          cyc = 0;     // rising edges seen
    int          err_cnt = 0;
    int          q_due[$];    // cycle at which each expectation is checked
    string       q_name[$];
    expect_t     q_exp[$];
    expect_t     cur_exp;
    string       cur_name;

    cop_bus_top #(
        .ROM_BANKS (ROM_BANKS)
    ) DUT (
        .clk      (clk),
        .rst      (rst),
        .bus      (bus),
        .cab      (cab),
        .lvbl     (lvbl),
        .dip_sw   (dip_sw),
        .cab_io   (cab_io),
        .sel      (sel),
        .rdata    (rdata),
        .obj_copy (obj_copy),
        .sec      (sec)
    );

    always #10 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    // service and coins in bits 5..3 and sec2 in bit 2
    function automatic logic [5:0] sec_of(input cab_in_t c);
        return {c.service, c.coin[1], c.coin[0], c.sec2, 2'b00};
    endfunction

    // 8KB window of a byte address without A23..22
    function automatic logic [23:0] win8k(input cpu_bus_t b);
        return {2'b00, b.addr[21:13], 13'h0000};
    endfunction

    function automatic logic count_up_hit(input cpu_bus_t b);
        return !b.as_n && b.rnw && (win8k(b) == 24'h244000);
    endfunction

    function automatic logic clear_hit(input cpu_bus_t b);
        return !b.as_n && !b.rnw && (win8k(b) == 24'h24A000);
    endfunction

    // expected selects from the region table
    function automatic chip_sel_t ref_decode(input cpu_bus_t b, input logic [1:0] bk);
        chip_sel_t   s;
        logic [23:0] ba;
        s  = '0;
        ba = {2'b00, b.addr[21:1], 1'b0};
        if (!b.as_n) begin
            if (ba[21:20] == 2'd0)
                s.rom = b.rnw && (int'(ba[19:16]) < ROM_BANKS);
            if ((ba & 24'hFFF000) == 24'h118000) s.front.map = (bk == 2'd1);
            if ((ba & 24'hFFF000) == 24'h11C000) s.back.map  = (bk == 2'd1);
            case (ba & 24'hFFE000)
                24'h248000: s.front.mode = 1'b1;
                24'h24C000: s.front.sft  = 1'b1;
                24'h24E000: s.front.map  = (bk == 2'd0);
                24'h262000, 24'h26E000: s.front.map = (bk == 2'd2);
                24'h270000: s.front.map  = (bk == 2'd3);
                24'h240000: s.back.mode  = 1'b1;
                24'h242000: s.back.sft   = 1'b1;
                24'h246000: s.back.map   = (bk == 2'd0);
                24'h260000: s.back.map   = (bk == 2'd2);
                24'h278000: s.back.map   = (bk == 2'd3);
                default: ;
            endcase
            case (ba & 24'hFFC000)
                24'h300000: begin
                    s.chr.mode = (ba[12:11] == 2'd0);
                    s.chr.map  = (ba[12:11] == 2'd1);
                    s.chr.sft  = (ba[12:11] == 2'd2);
                end
                24'h304000: s.sysram = 1'b1;
                24'h308000: s.obj    = 1'b1;
                24'h310000: s.pal[0] = 1'b1;
                24'h314000: begin
                    s.snreq   = (ba[3:1] == 3'd0);
                    s.prisel  = (ba[3:1] == 3'd1);
                    s.read[2] = b.rnw && (ba[3:1] == 3'd4);  // DIP
                    s.read[0] = b.rnw && (ba[3:1] == 3'd5);  // cabinet
                    s.read[1] = b.rnw && (ba[3:1] == 3'd6);  // system
                end
                24'h31C000: s.sysram = b.rnw;
                default: ;
            endcase
            s.disp = s.front.map | s.back.map | s.chr.map |
                     s.front.sft | s.back.sft | s.chr.sft;
        end
        return s;
    endfunction

    // read-back word is zero unless exactly one read port answers a read
    function automatic io_word_t ref_rdata(input chip_sel_t s, input logic rnw, input io_word_t dip,
                                           input io_word_t cio, input logic lv, input cab_in_t c);
        if (!rnw)
            return '0;
        case (s.read)
            3'b100:  return dip;
            3'b001:  return cio;
            3'b010:  return {8'h00, lv, 1'b0, sec_of(c)};
            default: return '0;
        endcase
    endfunction

    task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            err_cnt++;
            $display("** Error: %s expected %0h actual %0h", name, exp, act);
            $display("Simulation FAILED");
            $fatal(1, "value mismatch in %s", name);
        end
    endtask

    // one access of 3 strobe-low cycles and 1 idle cycle from a falling edge
    task automatic do_access(input string name, input logic [23:0] addr, input logic rnw,
                             input logic strobe);
        expect_t e;
        bus.addr = addr[23:1];
        bus.rnw  = rnw;
        bus.as_n = ~strobe;
        e.sel   = ref_decode(bus, bank_m);
        e.rdata = ref_rdata(e.sel, rnw, dip_sw, cab_io, lvbl, cab);
        e.sec   = sec_of(cab);
        q_due.push_back(cyc + 2);   // capture edge then the output register
        q_name.push_back(name);
        q_exp.push_back(e);
        if (clear_hit(bus))
            bank_m = 2'd0;
        else if (count_up_hit(bus))
            bank_m = bank_m + 2'd1;  // wraps mod 4
        repeat (3) @(negedge clk);
        bus.as_n = 1'b1;
        @(negedge clk);
    endtask

    // all bank-gated map windows with mirrors through A23..22
    task automatic probe_maps(input string tag);
        for (int i = 0; i < 9; i++) begin
            rnd = $random(seed);
            do_access($sformatf("%s map %h bank %0d", tag, MAP_ADDR[i], bank_m),
                      MAP_ADDR[i] | {rnd[1:0], 22'h0}, rnd[2], 1'b1);
        end
    endtask

    // compare on the falling edge when an expectation is due
    always @(negedge clk) begin
        if (q_due.size() > 0 && q_due[0] == cyc) begin
            void'(q_due.pop_front());
            cur_name = q_name.pop_front();
            cur_exp  = q_exp.pop_front();
            check_val({cur_name, " sel"}, 64'(cur_exp.sel), 64'(sel));
            check_val({cur_name, " rdata"}, 64'(cur_exp.rdata), 64'(rdata));
            check_val({cur_name, " sec"}, 64'(cur_exp.sec), 64'(sec));
        end
    end

    initial begin
        rst      = 1'b1;
        bus.addr = '0;
        bus.as_n = 1'b1;
        bus.rnw  = 1'b1;
        cab      = '0;
        lvbl     = 1'b1;   // visible area
        dip_sw   = '0;
        cab_io   = '0;
        bank_m   = 2'd0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // idle bus right after reset
        repeat (4) begin
            @(negedge clk);
            check_val("idle sel", 64'h0, 64'(sel));
            check_val("idle rdata", 64'h0, 64'(rdata));
            check_val("idle obj_copy", 64'h0, 64'(obj_copy));
        end
        for (int i = 0; i < 8; i++) begin
            rnd = $random(seed);
            do_access("strobe high", {rnd[23:1], 1'b0}, rnd[24], 1'b0);
        end

        // rom banks, reads then writes
        for (int b = 0; b < 16; b++) begin
            rnd = $random(seed);
            do_access($sformatf("rom read bank %0d", b),
                      {rnd[1:0], 2'b00, 4'(b), rnd[15:1], 1'b0}, 1'b1, 1'b1);
        end
        for (int b = 0; b < 4; b++) begin
            rnd = $random(seed);
            do_access($sformatf("rom write bank %0d", b),
                      {rnd[1:0], 2'b00, 4'(b), rnd[15:1], 1'b0}, 1'b0, 1'b1);
        end

        // bank 0,1,2,3 then wrap to 0
        for (int s = 0; s < 5; s++) begin
            probe_maps("step");
            rnd = $random(seed);
            do_access("count up", 24'h244000 | {11'h0, rnd[12:1], 1'b0}, 1'b1, 1'b1);
        end
        do_access("count up write", 24'h244000, 1'b0, 1'b1);    // wrong direction so no step
        do_access("count clear read", 24'h24A000, 1'b1, 1'b1);  // wrong direction so no clear
        probe_maps("bank held");
        do_access("count clear", 24'h24A000, 1'b0, 1'b1);
        probe_maps("after clear");

        // fixed windows both directions
        for (int i = 0; i < 16; i++) begin
            for (int rw = 0; rw < 2; rw++) begin
                rnd = $random(seed);
                do_access($sformatf("decode %h rnw %0d", DEC_ADDR[i], rw),
                          DEC_ADDR[i] | {rnd[1:0], 22'h0}, 1'(rw), 1'b1);
            end
        end

        // read ports with random pins
        for (int i = 0; i < 12; i++) begin
            rnd    = $random(seed);
            dip_sw = rnd[15:0];
            cab_io = rnd[31:16];
            rnd    = $random(seed);
            cab    = rnd[3:0];
            lvbl   = rnd[4];
            do_access("dip read", 24'h314008, 1'b1, 1'b1);
            do_access("cabinet read", 24'h31400A, 1'b1, 1'b1);
            do_access("system read", 24'h31400C, 1'b1, 1'b1);
            // a write to an input port reads back nothing
            do_access($sformatf("port write %0d", i % 3),
                      24'h314008 + 24'(2 * (i % 3)), 1'b0, 1'b1);
        end

        // vblank entry pulses on the second edge only
        lvbl = 1'b1;
        repeat (3) @(negedge clk);
        lvbl = 1'b0;
        for (int i = 1; i <= 4; i++) begin
            @(negedge clk);
            check_val($sformatf("obj_copy fall cycle %0d", i), 64'(i == 2), 64'(obj_copy));
        end
        lvbl = 1'b1;  // rising edge gives no pulse
        for (int i = 1; i <= 4; i++) begin
            @(negedge clk);
            check_val($sformatf("obj_copy rise cycle %0d", i), 64'h0, 64'(obj_copy));
        end

        if (err_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
        $display("Simulation FAILED");
        $fatal(1, "timeout");
    end

endmodule

// File: hdl/cop_addr_decoder.sv
// address decode table of the main CPU with the two-bit tilemap bank counter
`timescale 1ns/1ps

module cop_addr_decoder import cop_bus_pkg::*; #(
    parameter int ROM_BANKS = 6  // populated 64K-word ROM banks
) (
    input  logic      clk,
    input  logic      rst,
    input  cpu_bus_t  bus_q,     // captured bus
    output chip_sel_t sel_c      // combinational selects
);

    localparam logic [4:0] ROM_LIM = 5'(ROM_BANKS);  // one spare bit so 16 banks fit

    logic [23:1] a;       // short alias for the address
    logic [1:0]  bank;    // map bank picking the tilemap window
    logic        cnt_up;  // read at 0x244000
    logic        cnt_clr; // write at 0x24A000
    logic        up_l;
    logic        clr_l;

    assign a = bus_q.addr;

    // bank counter
    // counts on the first cycle of each count-up access only
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bank  <= 2'd0;
            up_l  <= 1'b0;
            clr_l <= 1'b0;
        end else begin
            up_l  <= cnt_up;
            clr_l <= cnt_clr;
            if (cnt_clr && !clr_l) begin
                bank <= 2'd0;          // clear has priority
            end else if (cnt_up && !up_l) begin
                bank <= bank + 2'd1;   // wraps after 3
            end
        end
    end

    // decode table
    // A23..22 not decoded so the map repeats every 4MB
    always_comb begin
        sel_c   = '0;
        cnt_up  = 1'b0;
        cnt_clr = 1'b0;
        if (!bus_q.as_n) begin
            case (a[21:20])
                2'd0: begin
                    // program ROM on reads only
                    sel_c.rom = bus_q.rnw && ({1'b0, a[19:16]} < ROM_LIM);
                end
                2'd1: begin
                    // extra map windows in bank 1 only
                    case (a[17:12])
                        6'h18:   sel_c.front.map = bank == 2'd1;  // 0x118000
                        6'h1c:   sel_c.back.map  = bank == 2'd1;  // 0x11C000
                        default: ;
                    endcase
                end
                2'd2: begin
                    if (a[19:18] == 2'b01) begin
                        // 8KB granularity with A12 ignored
                        case ({a[17:13], 1'b0})
                            6'h04: cnt_up  = bus_q.rnw;     // count-up read
                            6'h0a: cnt_clr = !bus_q.rnw;    // count-clear write
                            // front chip
                            6'h08: sel_c.front.mode = 1'b1;
                            6'h0c: sel_c.front.sft  = 1'b1;
                            6'h0e: sel_c.front.map  = bank == 2'd0;
                            6'h22,
                            6'h2e: sel_c.front.map  = bank == 2'd2;  // two mirrors
                            6'h30: sel_c.front.map  = bank == 2'd3;
                            // back chip
                            6'h00: sel_c.back.mode  = 1'b1;
                            6'h02: sel_c.back.sft   = 1'b1;
                            6'h06: sel_c.back.map   = bank == 2'd0;
                            6'h20: sel_c.back.map   = bank == 2'd2;
                            6'h38: sel_c.back.map   = bank == 2'd3;
                            default: ;
                        endcase
                    end
                end
                2'd3: begin
                    // 16KB blocks from 0x300000
                    case (a[19:14])
                        6'h00: begin
                            // char chip split by 2KB
                            case (a[12:11])
                                2'd0:    sel_c.chr.mode = 1'b1;
                                2'd1:    sel_c.chr.map  = 1'b1;
                                2'd2:    sel_c.chr.sft  = 1'b1;
                                default: ;
                            endcase
                        end
                        6'h01: sel_c.sysram = 1'b1;   // 0x304000
                        6'h02: sel_c.obj    = 1'b1;   // 0x308000
                        6'h04: sel_c.pal[0] = 1'b1;   // 0x310000
                        6'h05: begin
                            // I/O ports at 0x314000
                            // input ports only answer reads
                            case (a[3:1])
                                3'd0:    sel_c.snreq        = 1'b1;
                                3'd1:    sel_c.prisel       = 1'b1;
                                3'd4:    sel_c.read[RD_DIP] = bus_q.rnw;
                                3'd5:    sel_c.read[RD_CAB] = bus_q.rnw;
                                3'd6:    sel_c.read[RD_SYS] = bus_q.rnw;
                                default: ;
                            endcase
                        end
                        6'h07: sel_c.sysram = bus_q.rnw;  // 0x31C000 on the read side only
                        default: ;
                    endcase
                end
                default: ;
            endcase
            // tile chips want to know about any map or scroll access
            sel_c.disp = |{sel_c.front.map, sel_c.back.map, sel_c.chr.map,
                           sel_c.front.sft, sel_c.back.sft, sel_c.chr.sft};
        end
    end

endmodule

// File: hdl/cop_bus_capture.sv
// input stage of the decoder, registers the CPU bus and cabinet pins and flags vblank start
`timescale 1ns/1ps

module cop_bus_capture import cop_bus_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  cpu_bus_t bus,          // raw CPU pins
    input  cab_in_t  cab,          // raw cabinet pins
    input  logic     lvbl,         // low during vblank
    output cpu_bus_t bus_q,
    output cab_in_t  cab_q,
    output logic     lvbl_q,
    output logic     frame_start   // one cycle at vblank entry
);

    logic lvbl_l;  // lvbl_q one cycle later

    // bus register
    // as_n comes out of reset high so the decoder sees an idle bus
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bus_q.addr <= '0;
            bus_q.as_n <= 1'b1;   // idle strobe
            bus_q.rnw  <= 1'b1;
        end else begin
            bus_q <= bus;
        end
    end

    // cabinet inputs, plain sampling
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cab_q <= '0;
        end else begin
            cab_q <= cab;
        end
    end

    // vblank pipe, two stages for the edge detect
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lvbl_q <= 1'b0;
            lvbl_l <= 1'b0;   // both low so no pulse right after reset
        end else begin
            lvbl_q <= lvbl;
            lvbl_l <= lvbl_q;
        end
    end

    // high->low on LVBL means the frame is done
    // valid in the cycle after the first capture of the low level
    assign frame_start = lvbl_l & ~lvbl_q;

endmodule

// File: hdl/cop_bus_pkg.sv
// shared bus, select and cabinet input types for the main-CPU decoder, imported by every module
package cop_bus_pkg;

    // 68000-style bus as seen by the decoder
    typedef struct packed {
        logic [23:1] addr;   // word address
        logic        as_n;   // address strobe, low active
        logic        rnw;    // high on reads
    } cpu_bus_t;

    // cabinet inputs that end up in the system word
    typedef struct packed {
        logic       service;
        logic [1:0] coin;    // coin slots 2,1
        logic       sec2;
    } cab_in_t;

    // one tile-layer chip has three windows
    typedef struct packed {
        logic mode;  // control registers
        logic sft;   // row/column scroll
        logic map;   // tilemap RAM
    } tile_sel_t;

    // all chip selects leaving the decoder
    typedef struct packed {
        logic       rom;
        logic       prisel;     // priority register
        logic       sysram;
        logic       obj;        // sprite RAM, MIX on the board
        logic       snreq;      // sound latch
        logic       disp;       // any map or scroll access
        logic [1:0] pal;
        // read port one-hot
        // bit 0 cabinet, 1 system, 2 DIP
        logic [2:0] read;
        tile_sel_t  front;
        tile_sel_t  back;
        tile_sel_t  chr;
    } chip_sel_t;

    // read-back data word
    typedef logic [15:0] io_word_t;

    // read port bit positions
    localparam int RD_CAB = 0;
    localparam int RD_SYS = 1;
    localparam int RD_DIP = 2;

endpackage

// File: hdl/cop_bus_top.sv
// top of the main-CPU decoder, chains bus capture, decode table and read-back stage
`timescale 1ns/1ps

module cop_bus_top import cop_bus_pkg::*; #(
    parameter int ROM_BANKS = 6   // board fits six program ROM banks
) (
    input  logic       clk,
    input  logic       rst,
    // CPU side
    input  cpu_bus_t   bus,
    // cabinet and video timing
    input  cab_in_t    cab,
    input  logic       lvbl,
    input  io_word_t   dip_sw,
    input  io_word_t   cab_io,
    // to the chips
    output chip_sel_t  sel,
    output io_word_t   rdata,
    output logic       obj_copy,
    output logic [5:0] sec
);

    cpu_bus_t  bus_q;        // captured bus
    cab_in_t   cab_q;
    logic      lvbl_q;
    logic      frame_start;  // vblank entry
    chip_sel_t sel_c;        // unregistered selects

    // stage 1
    cop_bus_capture u_capture (
        .clk         (clk),
        .rst         (rst),
        .bus         (bus),
        .cab         (cab),
        .lvbl        (lvbl),
        .bus_q       (bus_q),
        .cab_q       (cab_q),
        .lvbl_q      (lvbl_q),
        .frame_start (frame_start)
    );

    // decode plus bank counter
    cop_addr_decoder #(
        .ROM_BANKS (ROM_BANKS)
    ) u_decoder (
        .clk   (clk),
        .rst   (rst),
        .bus_q (bus_q),
        .sel_c (sel_c)
    );

    // stage 2
    cop_io_read u_io_read (
        .clk         (clk),
        .rst         (rst),
        .sel_c       (sel_c),
        .cab_q       (cab_q),
        .lvbl_q      (lvbl_q),
        .frame_start (frame_start),
        .dip_sw      (dip_sw),
        .cab_io      (cab_io),
        .sel         (sel),
        .rdata       (rdata),
        .obj_copy    (obj_copy),
        .sec         (sec)
    );

endmodule

// File: hdl/cop_io_read.sv
// output stage of the decoder, registers the selects and builds the I/O read-back word
`timescale 1ns/1ps

module cop_io_read import cop_bus_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  chip_sel_t sel_c,        // from the decode table
    input  cab_in_t   cab_q,
    input  logic      lvbl_q,
    input  logic      frame_start,
    input  io_word_t  dip_sw,       // both DIP banks
    input  io_word_t  cab_io,       // joysticks and buttons
    output chip_sel_t sel,
    output io_word_t  rdata,
    output logic      obj_copy,     // sprite DMA trigger
    output logic [5:0] sec          // to the MCU side
);

    io_word_t sys_word;   // system port layout
    io_word_t rd_mux;

    // bit 2 sec2, bits 1..0 not wired on the board
    assign sec = {cab_q.service, cab_q.coin, cab_q.sec2, 2'b00};

    // LVBL at bit 7, bit 6 open
    assign sys_word = {8'h00, lvbl_q, 1'b0, sec};

    // one-hot port select, anything else reads as zero
    always_comb begin
        case (sel_c.read)
            3'b100:  rd_mux = dip_sw;
            3'b001:  rd_mux = cab_io;
            3'b010:  rd_mux = sys_word;
            default: rd_mux = '0;
        endcase
    end

    // second pipe stage
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel      <= '0;
            rdata    <= '0;
            obj_copy <= 1'b0;
        end else begin
            sel      <= sel_c;
            rdata    <= rd_mux;
            obj_copy <= frame_start;   // one pulse per frame
        end
    end

endmodule

// File: tb.f
hdl/cop_bus_pkg.sv
hdl/cop_bus_capture.sv
hdl/cop_addr_decoder.sv
hdl/cop_io_read.sv
hdl/cop_bus_top.sv
dv/cop_bus_tb.sv
